// ==== common/frame_uart_macros.svh ====
`ifndef FRAME_UART_MACROS_SVH
`define FRAME_UART_MACROS_SVH

// bits per pixel, also the uart payload width
`define FRAME_DATA_WIDTH 8

// image geometry
`define FRAME_IMG_WIDTH  4
`define FRAME_IMG_HEIGHT 4

`define FRAME_TOTAL_PIXELS (`FRAME_IMG_WIDTH * `FRAME_IMG_HEIGHT)
`define FRAME_ADDR_WIDTH   $clog2(`FRAME_TOTAL_PIXELS)

// clocks per 16x oversampling tick
`define FRAME_BAUD_DIV 4

`endif

// ==== common/frame_uart_pkg.sv ====
`default_nettype none

`include "frame_uart_macros.svh"

package frame_uart_pkg;

    // one pixel as written by the edge detector and sent on the line
    typedef logic [`FRAME_DATA_WIDTH-1:0] pixel_t;

    // frame buffer location
    typedef logic [`FRAME_ADDR_WIDTH-1:0] addr_t;

endpackage

`default_nettype wire

// ==== frame_uart_top.f ====
+incdir+common
common/frame_uart_pkg.sv
hw/pixel_capture.sv
hw/frame_buffer.sv
uart_tx/baud_tick_gen.sv
uart_tx/uart_tx.sv
hw/frame_uart_top.sv
verif/frame_uart_tb.sv

// ==== hw/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_uart_macros.svh"

module frame_buffer import frame_uart_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   we,
    input  pixel_t wdata,
    input  addr_t  waddr,
    input  logic   frame_tick,
    input  logic   re,
    output pixel_t rdata,
    output logic   frame_done
);
    localparam addr_t LAST_ADDR = addr_t'(`FRAME_TOTAL_PIXELS - 1);

    pixel_t mem [0:`FRAME_TOTAL_PIXELS-1];
    addr_t  rd_ptr;
    addr_t  next_ptr;

    // more bytes left behind the current one
    assign frame_done = (rd_ptr != LAST_ADDR);

    always_comb begin
        if (frame_tick) begin
            next_ptr = '0;
        end else if (re && frame_done) begin
            next_ptr = rd_ptr + 1'b1;
        end else begin
            // holds at the last byte once the frame has been walked
            next_ptr = rd_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= next_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // registered read, follows the pointer with one clock latency
        rdata <= mem[next_ptr];
    end

endmodule

`default_nettype wire

// ==== hw/frame_uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_uart_top import frame_uart_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   canny_de,
    input  pixel_t canny_data,
    output logic   tx
);
    logic   we;
    pixel_t wdata;
    addr_t  waddr;
    logic   frame_tick;
    logic   re;
    pixel_t tx_data;
    logic   frame_done;
    logic   b_tick;
    logic   start_trig;
    logic   tx_busy;
    logic   tx_done;

    pixel_capture u_pixel_capture (
        .clk        (clk),
        .reset      (reset),
        .canny_de   (canny_de),
        .canny_data (canny_data),
        .we         (we),
        .wdata      (wdata),
        .waddr      (waddr),
        .frame_tick (frame_tick)
    );

    // rewind on a new frame, step after each sent byte
    assign re = frame_tick | tx_done;

    frame_buffer u_frame_buffer (
        .clk        (clk),
        .reset      (reset),
        .we         (we),
        .wdata      (wdata),
        .waddr      (waddr),
        .frame_tick (frame_tick),
        .re         (re),
        .rdata      (tx_data),
        .frame_done (frame_done)
    );

    baud_tick_gen u_baud_tick_gen (
        .clk    (clk),
        .reset  (reset),
        .b_tick (b_tick)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .start_trig (start_trig),
        .tx_data    (tx_data),
        .b_tick     (b_tick),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done)
    );

    // one clock behind the read request, so rdata has settled
    always_ff @(posedge clk) begin
        if (reset) begin
            start_trig <= 1'b0;
        end else begin
            start_trig <= frame_tick | (tx_done & ~tx_busy & frame_done);
        end
    end

endmodule

`default_nettype wire

// ==== hw/pixel_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_uart_macros.svh"

module pixel_capture import frame_uart_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   canny_de,
    input  pixel_t canny_data,
    output logic   we,
    output pixel_t wdata,
    output addr_t  waddr,
    output logic   frame_tick
);
    localparam addr_t LAST_ADDR = addr_t'(`FRAME_TOTAL_PIXELS - 1);

    localparam logic COLLECT   = 1'b0;
    localparam logic END_FRAME = 1'b1;

    logic  state;
    addr_t addr_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= COLLECT;
            addr_cnt   <= '0;
            we         <= 1'b0;
            frame_tick <= 1'b0;
        end else begin
            we <= canny_de;
            // pulse one clock after the last write
            frame_tick <= (state == END_FRAME);
            if (canny_de) begin
                addr_cnt <= (addr_cnt == LAST_ADDR) ? '0 : addr_cnt + 1'b1;
            end
            case (state)
                COLLECT: begin
                    if (canny_de && addr_cnt == LAST_ADDR) begin
                        state <= END_FRAME;
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    // write payload, qualified by we
    always_ff @(posedge clk) begin
        if (canny_de) begin
            wdata <= canny_data;
            waddr <= addr_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame dump testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=frame_uart_sim

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module frame_uart_tb -f frame_uart_top.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Testbench passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// ==== uart_tx/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_uart_macros.svh"

module baud_tick_gen (
    input  logic clk,
    input  logic reset,
    output logic b_tick
);
    localparam int CNT_W = (`FRAME_BAUD_DIV > 1) ? $clog2(`FRAME_BAUD_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`FRAME_BAUD_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // free running, never restarted by the transmitter
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            b_tick <= 1'b0;
        end else begin
            cnt    <= (cnt == CNT_MAX) ? '0 : cnt + 1'b1;
            b_tick <= (cnt == CNT_MAX);
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_uart_macros.svh"

module uart_tx import frame_uart_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   start_trig,
    input  pixel_t tx_data,
    input  logic   b_tick,
    output logic   tx,
    output logic   tx_busy,
    output logic   tx_done
);
    localparam int BIT_W = $clog2(`FRAME_DATA_WIDTH);
    localparam logic [3:0]       LAST_TICK = 4'd15;
    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(`FRAME_DATA_WIDTH - 1);

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] START = 2'd1;
    localparam logic [1:0] DATA  = 2'd2;
    localparam logic [1:0] STOP  = 2'd3;

    logic [1:0]       state;
    logic [3:0]       tick_cnt;
    logic [BIT_W-1:0] bit_idx;
    pixel_t           data_reg;

    // line level straight from the state, lsb first
    always_comb begin
        case (state)
            START:   tx = 1'b0;
            DATA:    tx = data_reg[bit_idx];
            default: tx = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx_busy  <= 1'b0;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_trig) begin
                        state    <= START;
                        tick_cnt <= '0;
                        tx_busy  <= 1'b1;
                    end
                end
                START: begin
                    if (b_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            bit_idx  <= '0;
                            state    <= DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (b_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            tick_cnt <= '0;
                            if (bit_idx == LAST_BIT) begin
                                state <= STOP;
                            end else begin
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (b_tick) begin
                        if (tick_cnt == LAST_TICK) begin
                            // busy drops in the same edge so the next trigger is allowed
                            state   <= IDLE;
                            tx_busy <= 1'b0;
                            tx_done <= 1'b1;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // byte latched once per start
    always_ff @(posedge clk) begin
        if (state == IDLE && start_trig) begin
            data_reg <= tx_data;
        end
    end

endmodule

`default_nettype wire

// ==== verif/frame_uart_stimulus.txt ====
// each word: gap count in the upper byte, pixel value in the lower byte
// the gap is the number of idle clocks before the pixel, the pixel is also the expected byte

// frame 1, one image row per line, no gaps
0000 00ff 0012 0034
0056 0078 009a 00bc
00de 00f0 000f 0081
0042 0024 00c3 003c

// frame 2, one image row per line, irregular gaps
03a5 005a 0111 07ee
0233 0000 05cc 0199
0480 0001 06fe 027f
00c0 0903 0155 02aa

// ==== verif/frame_uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frame_uart_macros.svh"

module frame_uart_tb import frame_uart_pkg::*; ();

    localparam int NUM_FRAMES     = 2;
    localparam int FRAME_PIXELS   = `FRAME_TOTAL_PIXELS;
    localparam int NUM_ENTRIES    = NUM_FRAMES * FRAME_PIXELS;
    localparam int CLKS_PER_BIT   = 16 * `FRAME_BAUD_DIV;
    localparam int BYTE_BUDGET    = 700;
    localparam int IDLE_TAIL      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_PIXELS * BYTE_BUDGET + 2000;

    logic   clk;
    logic   reset;
    logic   canny_de;
    pixel_t canny_data;
    logic   tx;

    // upper byte gap count, lower byte pixel
    logic [15:0] stim [0:NUM_ENTRIES-1];

    int   mismatch_count;
    int   failure_count;
    int   cycle_count;
    int   bytes_received;
    logic expect_idle;

    frame_uart_top dut (
        .clk        (clk),
        .reset      (reset),
        .canny_de   (canny_de),
        .canny_data (canny_data),
        .tx         (tx)
    );

    always #50 clk = ~clk;

    task automatic check_pixel(input pixel_t expected, input pixel_t actual, input int index);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: byte %0d received 0x%02h, expected 0x%02h",
                     $time, index, actual, expected);
        end
    endtask

    task automatic check_bit(input logic expected, input logic actual, input string label);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t ns: %s is %b, expected %b",
                     $time, label, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d bytes received",
                 mismatch_count, failure_count, bytes_received, NUM_ENTRIES);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // one frame of pixels, each after its own idle gap
    task automatic drive_frame(input int frame);
        int base;
        int gap;
        base = frame * FRAME_PIXELS;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            gap = int'(stim[base + i][15:8]);
            repeat (gap) begin
                @(posedge clk);
                #1;
                canny_de = 1'b0;
            end
            @(posedge clk);
            #1;
            canny_de   = 1'b1;
            canny_data = stim[base + i][7:0];
        end
        @(posedge clk);
        #1;
        canny_de = 1'b0;
    endtask

    task automatic wait_for_bytes(input int count);
        while (bytes_received < count) begin
            @(posedge clk);
        end
    endtask

    // called half a clock into the start bit, samples each bit near its middle
    task automatic receive_byte();
        pixel_t rx_byte;
        int     index;
        index = bytes_received;
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        check_bit(1'b0, tx, "start bit");
        for (int b = 0; b < `FRAME_DATA_WIDTH; b++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            rx_byte[b] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_bit(1'b1, tx, "stop bit");
        if (index < NUM_ENTRIES) begin
            check_pixel(pixel_t'(stim[index][7:0]), rx_byte, index);
        end else begin
            failure_count++;
            $display("an extra byte 0x%02h arrived after the last frame at %0t ns",
                     rx_byte, $time);
        end
        bytes_received = index + 1;
    endtask

    // serial line monitor, stop bit is still high when it returns
    initial begin
        wait (reset == 1'b0);
        forever begin
            @(negedge clk);
            if (tx == 1'b0) begin
                receive_byte();
            end
        end
    end

    // no start bit allowed while a frame is incomplete or after the last byte
    always @(negedge clk) begin
        if (expect_idle) begin
            check_bit(1'b1, tx, "idle line");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            failure_count++;
            $display("the run timed out after %0d cycles without receiving all bytes",
                     cycle_count);
            finish_run();
        end
    end

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        canny_de       = 1'b0;
        canny_data     = '0;
        mismatch_count = 0;
        failure_count  = 0;
        cycle_count    = 0;
        bytes_received = 0;
        expect_idle    = 1'b1;
        $readmemh("verif/frame_uart_stimulus.txt", stim);
        if ($isunknown(stim[NUM_ENTRIES-1])) begin
            failure_count++;
            $display("the stimulus file could not be read completely");
        end

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        // frame 1 back to back
        drive_frame(0);
        expect_idle = 1'b0;
        wait_for_bytes(FRAME_PIXELS);

        // frame 2 with gaps, only once frame 1 is fully out
        expect_idle = 1'b1;
        drive_frame(1);
        expect_idle = 1'b0;
        wait_for_bytes(NUM_ENTRIES);

        expect_idle = 1'b1;
        repeat (IDLE_TAIL) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire
